//--- flist.f
logic/axis_in_pkg.sv
logic/axis_in_lane_ram.sv
logic/axis_in_packer.sv
logic/axis_in_reader.sv
logic/axis_in_csr.sv
logic/axis_in_top.sv
verification/axis_in_tb.sv

//--- Bender.yml
package:
  name: axis_in

sources:
  - logic/axis_in_pkg.sv
  - logic/axis_in_lane_ram.sv
  - logic/axis_in_packer.sv
  - logic/axis_in_reader.sv
  - logic/axis_in_csr.sv
  - logic/axis_in_top.sv
  - target: test
    files:
      - verification/axis_in_tb.sv

//--- verification/axis_in_tb.sv
//==========================================================================
// Testbench of the AXI-Stream input peripheral: clock, reset, LFSR stimulus,
// reference packing function, word comparator and watchdog
//==========================================================================

module axis_in_tb
   import axis_in_pkg::*;
;

   localparam int DATA_W     = TDATA_W_DEF * LANES_DEF;
   localparam int CLK_PERIOD = 10;
   localparam int RST_CYCLES = 5;
   localparam int C1_PKTS    = 6;
   localparam int C2_PKTS    = 6;
   localparam int FILL_WORDS = 2 ** ADDR_W_DEF + 1;
   localparam int THRESH     = 10;

   // Longest packets of checks 1 and 2 plus the fixed lengths of checks 3 to 5
   localparam int TOTAL_BEATS = C1_PKTS * 24 + C2_PKTS * 31 + 9 + 8 +
                                FILL_WORDS * LANES_DEF + 4 + 10 + 6;
   localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 40 + 2000;

   localparam logic [CSR_DATA_W-1:0] CTRL_STREAM = 32'((1 << CTRL_ENABLE) | (1 << CTRL_MODE));
   localparam logic [CSR_DATA_W-1:0] CTRL_REG_RST =
      32'((1 << CTRL_ENABLE) | (1 << CTRL_SOFT_RST));

   logic                  clk = 1'b0;
   logic                  rst_n;
   logic                  axis_tvalid;
   logic                  axis_tready;
   logic [TDATA_W_DEF-1:0] axis_tdata;
   logic                  axis_tlast;
   logic                  sys_tvalid;
   logic                  sys_tready;
   logic [     DATA_W-1:0] sys_tdata;
   logic                  csr_we;
   logic                  csr_re;
   logic [ CSR_ADDR_W-1:0] csr_addr;
   logic [ CSR_DATA_W-1:0] csr_wdata;
   logic [ CSR_DATA_W-1:0] csr_rdata;
   logic                  csr_rvalid;
   logic                  interrupt;

   logic [31:0]            lfsr_q = 32'h3a3f;
   logic [TDATA_W_DEF-1:0] beat_q[$];
   logic [     DATA_W-1:0] exp_q[$];
   int                     sink_mode;
   logic                   data_cmp;
   int                     err_val = 0;
   int                     err_other = 0;

   axis_in_top dut_i (
      .clk_i        (clk),
      .rst_n_i      (rst_n),
      .axis_tvalid_i(axis_tvalid),
      .axis_tready_o(axis_tready),
      .axis_tdata_i (axis_tdata),
      .axis_tlast_i (axis_tlast),
      .sys_tvalid_o (sys_tvalid),
      .sys_tready_i (sys_tready),
      .sys_tdata_o  (sys_tdata),
      .csr_we_i     (csr_we),
      .csr_re_i     (csr_re),
      .csr_addr_i   (csr_addr),
      .csr_wdata_i  (csr_wdata),
      .csr_rdata_o  (csr_rdata),
      .csr_rvalid_o (csr_rvalid),
      .interrupt_o  (interrupt)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // Taps 32, 22, 2 and 1 with one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int b = 0; b < n; b++) begin
         lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
         r = {r[30:0], lfsr_q[0]};
      end
      return r;
   endfunction

   // Lane l of a word holds beat first+l and zero past the packet end
   function automatic logic [DATA_W-1:0] pack_ref(input int first, input int len);
      logic [DATA_W-1:0] w;
      w = '0;
      for (int l = 0; l < LANES_DEF; l++) begin
         if (first + l < len) begin
            w[l*TDATA_W_DEF+:TDATA_W_DEF] = beat_q[first+l];
         end
      end
      return w;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      err_val++;
   endtask

   task automatic take_word(input string name, input logic [DATA_W-1:0] got);
      logic [DATA_W-1:0] exp;
      if (exp_q.size() == 0) begin
         $display("At %0t a word %h left on %s while none was expected", $time, got, name);
         err_other++;
      end else begin
         exp = exp_q.pop_front();
         if (got !== exp) begin
            report_mismatch(name, got, exp);
         end
      end
   endtask

   // Handshakes are taken at the edge where they happen
   always @(posedge clk) begin
      if (sys_tvalid && sys_tready) begin
         take_word("sys_tdata_o", sys_tdata);
      end
      if (csr_rvalid && data_cmp) begin
         take_word("csr_rdata_o", csr_rdata);
      end
   end

   // Sink mode 0 stalls and 1 is always ready while other values back-pressure at random
   always @(negedge clk) begin
      case (sink_mode)
         0:       sys_tready = 1'b0;
         1:       sys_tready = 1'b1;
         default: sys_tready = (rand_bits(1) != 0);
      endcase
   end

   task automatic csr_write(input logic [CSR_ADDR_W-1:0] addr,
                            input logic [CSR_DATA_W-1:0] data);
      @(negedge clk);
      csr_we    = 1'b1;
      csr_addr  = addr;
      csr_wdata = data;
      @(negedge clk);
      csr_we = 1'b0;
   endtask

   task automatic csr_read(input logic [CSR_ADDR_W-1:0] addr,
                           output logic [CSR_DATA_W-1:0] data);
      @(negedge clk);
      csr_re   = 1'b1;
      csr_addr = addr;
      @(negedge clk);
      csr_re = 1'b0;
      while (!csr_rvalid) begin
         @(negedge clk);
      end
      data = csr_rdata;
   endtask

   // DATA read whose result goes through the comparator once the rvalid
   // of an earlier read has dropped
   task automatic read_data_word();
      logic [CSR_DATA_W-1:0] d;
      @(negedge clk);
      data_cmp = 1'b1;
      csr_read(CSR_DATA, d);
      @(negedge clk);
      data_cmp = 1'b0;
   endtask

   task automatic read_words(input int n);
      logic [CSR_DATA_W-1:0] st;
      for (int w = 0; w < n; w++) begin
         csr_read(CSR_STATUS, st);
         while (st[ST_EMPTY]) begin
            csr_read(CSR_STATUS, st);
         end
         read_data_word();
      end
   endtask

   // Beats and expected words are queued before the first beat goes out
   task automatic send_packet(input int len, input bit with_last);
      logic [31:0] r;
      int          n;
      beat_q.delete();
      for (int i = 0; i < len; i++) begin
         r = rand_bits(TDATA_W_DEF);
         beat_q.push_back(r[TDATA_W_DEF-1:0]);
      end
      n = (len + LANES_DEF - 1) / LANES_DEF;
      for (int w = 0; w < n; w++) begin
         exp_q.push_back(pack_ref(w * LANES_DEF, len));
      end
      @(negedge clk);
      for (int i = 0; i < len; i++) begin
         while (rand_bits(2) == 0) begin
            axis_tvalid = 1'b0;
            @(negedge clk);
         end
         axis_tvalid = 1'b1;
         axis_tdata  = beat_q[i];
         axis_tlast  = with_last && (i == len - 1);
         // Ready has no path from valid and is already final here
         while (!axis_tready) begin
            @(negedge clk);
         end
         @(negedge clk);
      end
      axis_tvalid = 1'b0;
      axis_tlast  = 1'b0;
   endtask

   task automatic wait_drained();
      while (exp_q.size() != 0) begin
         @(negedge clk);
      end
   endtask

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Timeout: the run did not end within %0d cycles", WATCHDOG_CYCLES);
      $display("Errors found");
      $finish;
   end

   initial begin
      logic [CSR_DATA_W-1:0] v;
      int                    len;
      rst_n       = 1'b0;
      axis_tvalid = 1'b0;
      axis_tdata  = '0;
      axis_tlast  = 1'b0;
      sys_tready  = 1'b0;
      csr_we      = 1'b0;
      csr_re      = 1'b0;
      csr_addr    = '0;
      csr_wdata   = '0;
      sink_mode   = 0;
      data_cmp    = 1'b0;
      repeat (RST_CYCLES) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      if (axis_tready !== 1'b0) report_mismatch("axis_tready_o", axis_tready, 0);
      if (sys_tvalid !== 1'b0) report_mismatch("sys_tvalid_o", sys_tvalid, 0);
      if (interrupt !== 1'b0) report_mismatch("interrupt_o", interrupt, 0);
      if (csr_rvalid !== 1'b0) report_mismatch("csr_rvalid_o", csr_rvalid, 0);

      // Stream mode, whole words, gaps and back-pressure
      csr_write(CSR_CTRL, CTRL_STREAM);
      sink_mode = 2;
      for (int p = 0; p < C1_PKTS; p++) begin
         len = (rand_bits(3) % 6 + 1) * LANES_DEF;
         send_packet(len, 1'b1);
      end
      wait_drained();

      // Packets ending mid-word
      for (int p = 0; p < C2_PKTS; p++) begin
         len = rand_bits(3) * LANES_DEF + 1 + rand_bits(2) % 3;
         send_packet(len, 1'b1);
      end
      wait_drained();

      // Register mode with input closed after tlast
      sink_mode = 0;
      csr_write(CSR_CTRL, CTRL_REG_RST);
      send_packet(9, 1'b1);
      axis_tvalid = 1'b1;
      repeat (8) begin
         axis_tdata = TDATA_W_DEF'(rand_bits(TDATA_W_DEF));
         if (axis_tready !== 1'b0) report_mismatch("axis_tready_o", axis_tready, 0);
         @(negedge clk);
      end
      axis_tvalid = 1'b0;
      csr_read(CSR_NWORDS, v);
      if (v !== 32'd9) report_mismatch("NWORDS", v, 9);
      csr_read(CSR_STATUS, v);
      if (v[ST_TLAST] !== 1'b1) report_mismatch("STATUS.tlast", v[ST_TLAST], 1);
      read_words(3);
      csr_read(CSR_DATA, v);
      if (v !== '0) report_mismatch("csr_rdata_o", v, 0);

      // Fill to depth plus the held word and drain against the threshold
      csr_write(CSR_CTRL, CTRL_REG_RST);
      csr_write(CSR_THRESH, THRESH);
      send_packet(FILL_WORDS * LANES_DEF, 1'b0);
      axis_tvalid = 1'b1;
      repeat (4) begin
         if (axis_tready !== 1'b0) report_mismatch("axis_tready_o", axis_tready, 0);
         @(negedge clk);
      end
      axis_tvalid = 1'b0;
      csr_read(CSR_STATUS, v);
      if (v[ST_FULL] !== 1'b1) report_mismatch("STATUS.full", v[ST_FULL], 1);
      for (int k = FILL_WORDS; k >= 0; k--) begin
         csr_read(CSR_LEVEL, v);
         if (v !== k) report_mismatch("LEVEL", v, k);
         if (interrupt !== (k >= THRESH)) report_mismatch("interrupt_o", interrupt, k >= THRESH);
         if (k > 0) begin
            read_data_word();
         end
      end

      // Soft reset discards a stored packet
      send_packet(10, 1'b1);
      csr_read(CSR_NWORDS, v);
      // The fill beats carried no tlast and still count here
      if (v !== FILL_WORDS * LANES_DEF + 10) begin
         report_mismatch("NWORDS", v, FILL_WORDS * LANES_DEF + 10);
      end
      csr_write(CSR_CTRL, CTRL_REG_RST);
      exp_q.delete();
      csr_read(CSR_STATUS, v);
      if (v !== 32'(1 << ST_EMPTY)) report_mismatch("STATUS", v, 32'(1 << ST_EMPTY));
      csr_read(CSR_NWORDS, v);
      if (v !== '0) report_mismatch("NWORDS", v, 0);
      send_packet(6, 1'b1);
      read_words(2);
      if (exp_q.size() != 0) begin
         $display("%0d expected words were never read out", exp_q.size());
         err_other++;
      end

      $display("Run complete: %0d value errors, %0d other failures", err_val, err_other);
      if (err_val + err_other == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

//--- logic/axis_in_top.sv
//==========================================================================
// AXI-Stream input peripheral top: packer, lane banks, reader, registers
//==========================================================================

module axis_in_top
   import axis_in_pkg::*;
#(
   parameter  int TDATA_W = TDATA_W_DEF,
   parameter  int LANES   = LANES_DEF,
   parameter  int ADDR_W  = ADDR_W_DEF,
   localparam int DATA_W  = TDATA_W * LANES
) (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  axis_tvalid_i,
   output logic                  axis_tready_o,
   input  logic [   TDATA_W-1:0] axis_tdata_i,
   input  logic                  axis_tlast_i,
   output logic                  sys_tvalid_o,
   input  logic                  sys_tready_i,
   output logic [    DATA_W-1:0] sys_tdata_o,
   input  logic                  csr_we_i,
   input  logic                  csr_re_i,
   input  logic [CSR_ADDR_W-1:0] csr_addr_i,
   input  logic [CSR_DATA_W-1:0] csr_wdata_i,
   output logic [CSR_DATA_W-1:0] csr_rdata_o,
   output logic                  csr_rvalid_o,
   output logic                  interrupt_o
);

   logic                  sw_rst;
   logic                  enable;
   logic                  mode;
   logic [     LANES-1:0] lane_we;
   logic [   TDATA_W-1:0] lane_wdata;
   logic [    ADDR_W-1:0] wr_addr;
   logic                  word_commit;
   logic [CSR_DATA_W-1:0] nwords;
   logic                  tlast_seen;
   logic                  rd_en;
   logic [    ADDR_W-1:0] rd_addr;
   logic [    DATA_W-1:0] rd_data;
   logic                  fifo_full;
   logic                  fifo_empty;
   logic [      ADDR_W:0] level;
   logic                  out_valid;
   logic [    DATA_W-1:0] out_data;
   logic                  data_pop;

   axis_in_packer #(
      .TDATA_W(TDATA_W),
      .LANES  (LANES),
      .ADDR_W (ADDR_W)
   ) packer_i (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .sw_rst_i     (sw_rst),
      .enable_i     (enable),
      .mode_i       (mode),
      .fifo_full_i  (fifo_full),
      .axis_tvalid_i(axis_tvalid_i),
      .axis_tdata_i (axis_tdata_i),
      .axis_tlast_i (axis_tlast_i),
      .axis_tready_o(axis_tready_o),
      .lane_we_o    (lane_we),
      .lane_wdata_o (lane_wdata),
      .wr_addr_o    (wr_addr),
      .word_commit_o(word_commit),
      .nwords_o     (nwords),
      .tlast_seen_o (tlast_seen)
   );

   // Lane 0 sits in the lowest bits of the packed word
   for (genvar i = 0; i < LANES; i++) begin : gen_lane
      axis_in_lane_ram #(
         .TDATA_W(TDATA_W),
         .ADDR_W (ADDR_W)
      ) lane_ram_i (
         .clk_i  (clk_i),
         .we_i   (lane_we[i]),
         .waddr_i(wr_addr),
         .wdata_i(lane_wdata),
         .re_i   (rd_en),
         .raddr_i(rd_addr),
         .rdata_o(rd_data[i*TDATA_W+:TDATA_W])
      );
   end

   axis_in_reader #(
      .TDATA_W(TDATA_W),
      .LANES  (LANES),
      .ADDR_W (ADDR_W)
   ) reader_i (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .sw_rst_i     (sw_rst),
      .mode_i       (mode),
      .word_commit_i(word_commit),
      .rd_data_i    (rd_data),
      .data_pop_i   (data_pop),
      .sys_tready_i (sys_tready_i),
      .rd_en_o      (rd_en),
      .rd_addr_o    (rd_addr),
      .fifo_full_o  (fifo_full),
      .fifo_empty_o (fifo_empty),
      .level_o      (level),
      .out_valid_o  (out_valid),
      .out_data_o   (out_data),
      .sys_tvalid_o (sys_tvalid_o),
      .sys_tdata_o  (sys_tdata_o)
   );

   axis_in_csr #(
      .TDATA_W(TDATA_W),
      .LANES  (LANES),
      .ADDR_W (ADDR_W)
   ) csr_i (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .csr_we_i    (csr_we_i),
      .csr_re_i    (csr_re_i),
      .csr_addr_i  (csr_addr_i),
      .csr_wdata_i (csr_wdata_i),
      .level_i     (level),
      .fifo_empty_i(fifo_empty),
      .fifo_full_i (fifo_full),
      .tlast_seen_i(tlast_seen),
      .nwords_i    (nwords),
      .out_valid_i (out_valid),
      .out_data_i  (out_data),
      .csr_rdata_o (csr_rdata_o),
      .csr_rvalid_o(csr_rvalid_o),
      .enable_o    (enable),
      .mode_o      (mode),
      .sw_rst_o    (sw_rst),
      .data_pop_o  (data_pop),
      .interrupt_o (interrupt_o)
   );

endmodule

//--- logic/axis_in_csr.sv
//==========================================================================
// Register file: CTRL and THRESH, soft reset pulse, read data path,
// DATA register pop and the FIFO level interrupt
//==========================================================================

module axis_in_csr
   import axis_in_pkg::*;
#(
   parameter  int TDATA_W = TDATA_W_DEF,
   parameter  int LANES   = LANES_DEF,
   parameter  int ADDR_W  = ADDR_W_DEF,
   localparam int DATA_W  = TDATA_W * LANES
) (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  csr_we_i,
   input  logic                  csr_re_i,
   input  logic [CSR_ADDR_W-1:0] csr_addr_i,
   input  logic [CSR_DATA_W-1:0] csr_wdata_i,
   input  logic [      ADDR_W:0] level_i,
   input  logic                  fifo_empty_i,
   input  logic                  fifo_full_i,
   input  logic                  tlast_seen_i,
   input  logic [CSR_DATA_W-1:0] nwords_i,
   input  logic                  out_valid_i,
   input  logic [    DATA_W-1:0] out_data_i,
   output logic [CSR_DATA_W-1:0] csr_rdata_o,
   output logic                  csr_rvalid_o,
   output logic                  enable_o,
   output logic                  mode_o,
   output logic                  sw_rst_o,
   output logic                  data_pop_o,
   output logic                  interrupt_o
);

   logic                  enable_q;
   logic                  mode_q;
   logic                  sw_rst_q;
   logic [      ADDR_W:0] thresh_q;
   logic [CSR_DATA_W-1:0] rdata_d;
   logic [CSR_DATA_W-1:0] rdata_q;
   logic                  rvalid_q;
   logic                  ctrl_wr;

   assign ctrl_wr = csr_we_i & (csr_addr_i == CSR_CTRL);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         enable_q <= 1'b0;
         mode_q   <= 1'b0;
         sw_rst_q <= 1'b0;
         thresh_q <= '0;
      end else begin
         // Soft reset bit is never stored, only pulsed
         sw_rst_q <= ctrl_wr & csr_wdata_i[CTRL_SOFT_RST];
         if (ctrl_wr) begin
            enable_q <= csr_wdata_i[CTRL_ENABLE];
            mode_q   <= csr_wdata_i[CTRL_MODE];
         end
         if (csr_we_i && csr_addr_i == CSR_THRESH) begin
            thresh_q <= csr_wdata_i[ADDR_W:0];
         end
      end
   end

   always_comb begin
      rdata_d = '0;
      case (csr_addr_i)
         CSR_CTRL: begin
            rdata_d[CTRL_ENABLE] = enable_q;
            rdata_d[CTRL_MODE]   = mode_q;
         end
         CSR_THRESH: rdata_d = CSR_DATA_W'(thresh_q);
         CSR_STATUS: begin
            rdata_d[ST_EMPTY] = fifo_empty_i;
            rdata_d[ST_FULL]  = fifo_full_i;
            rdata_d[ST_TLAST] = tlast_seen_i;
         end
         CSR_LEVEL:  rdata_d = CSR_DATA_W'(level_i);
         CSR_NWORDS: rdata_d = nwords_i;
         // Nothing held reads as zero
         CSR_DATA:   rdata_d = out_valid_i ? CSR_DATA_W'(out_data_i) : '0;
         default:    rdata_d = '0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= csr_re_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (csr_re_i) begin
         rdata_q <= rdata_d;
      end
   end

   assign csr_rdata_o  = rdata_q;
   assign csr_rvalid_o = rvalid_q;
   assign enable_o     = enable_q;
   assign mode_o       = mode_q;
   assign sw_rst_o     = sw_rst_q;

   // Pop only in register mode and only a word that is really there
   assign data_pop_o = csr_re_i & (csr_addr_i == CSR_DATA) & ~mode_q & out_valid_i;

   // Threshold of zero keeps the interrupt off
   assign interrupt_o = (thresh_q != '0) & (level_i >= thresh_q);

endmodule

//--- logic/axis_in_reader.sv
//==========================================================================
// FIFO read side: read pointer, word count, flags and the one-word
// holding stage that feeds the system stream and the DATA register
//==========================================================================

module axis_in_reader
   import axis_in_pkg::*;
#(
   parameter  int TDATA_W = TDATA_W_DEF,
   parameter  int LANES   = LANES_DEF,
   parameter  int ADDR_W  = ADDR_W_DEF,
   localparam int DATA_W  = TDATA_W * LANES
) (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic              sw_rst_i,
   input  logic              mode_i,
   input  logic              word_commit_i,
   input  logic [DATA_W-1:0] rd_data_i,
   input  logic              data_pop_i,
   input  logic              sys_tready_i,
   output logic              rd_en_o,
   output logic [ADDR_W-1:0] rd_addr_o,
   output logic              fifo_full_o,
   output logic              fifo_empty_o,
   output logic [  ADDR_W:0] level_o,
   output logic              out_valid_o,
   output logic [DATA_W-1:0] out_data_o,
   output logic              sys_tvalid_o,
   output logic [DATA_W-1:0] sys_tdata_o
);

   localparam int DEPTH = 2 ** ADDR_W;

   logic [ADDR_W-1:0] rd_ptr_q;
   logic [  ADDR_W:0] count_q;
   logic              hold_q;
   logic              consume;

   // Held word leaves by sys_tready in stream mode, by a DATA read otherwise
   assign consume = hold_q & (mode_i ? sys_tready_i : data_pop_i);

   // Read as soon as the holding stage is free or freeing up
   assign rd_en_o   = (~hold_q | consume) & (count_q != '0);
   assign rd_addr_o = rd_ptr_q;

   assign fifo_full_o  = (count_q == (ADDR_W + 1)'(DEPTH));
   assign level_o      = count_q + {{ADDR_W{1'b0}}, hold_q};
   assign fifo_empty_o = (level_o == '0);

   // The bank output registers double as the holding stage data
   assign out_valid_o  = hold_q;
   assign out_data_o   = rd_data_i;
   assign sys_tvalid_o = hold_q & mode_i;
   assign sys_tdata_o  = rd_data_i;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i || sw_rst_i) begin
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (rd_en_o) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({word_commit_i, rd_en_o})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // Read in flight becomes the held word at the next edge
   always_ff @(posedge clk_i) begin
      if (!rst_n_i || sw_rst_i) begin
         hold_q <= 1'b0;
      end else if (rd_en_o) begin
         hold_q <= 1'b1;
      end else if (consume) begin
         hold_q <= 1'b0;
      end
   end

endmodule

//--- logic/axis_in_packer.sv
//==========================================================================
// Input stream packer: handshake, lane select, tlast padding FSM,
// accepted beat counter and word commit towards the lane banks
//==========================================================================

module axis_in_packer
   import axis_in_pkg::*;
#(
   parameter int TDATA_W = TDATA_W_DEF,
   parameter int LANES   = LANES_DEF,
   parameter int ADDR_W  = ADDR_W_DEF
) (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  sw_rst_i,
   input  logic                  enable_i,
   input  logic                  mode_i,
   input  logic                  fifo_full_i,
   input  logic                  axis_tvalid_i,
   input  logic [   TDATA_W-1:0] axis_tdata_i,
   input  logic                  axis_tlast_i,
   output logic                  axis_tready_o,
   output logic [     LANES-1:0] lane_we_o,
   output logic [   TDATA_W-1:0] lane_wdata_o,
   output logic [    ADDR_W-1:0] wr_addr_o,
   output logic                  word_commit_o,
   output logic [CSR_DATA_W-1:0] nwords_o,
   output logic                  tlast_seen_o
);

   localparam int LANE_W = (LANES > 1) ? $clog2(LANES) : 1;
   localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(LANES - 1);

   // FSM states
   localparam logic ST_ACCEPT = 1'b0;
   localparam logic ST_PAD    = 1'b1;

   logic                  state_q;
   logic [    LANE_W-1:0] lane_q;
   logic [    ADDR_W-1:0] wr_ptr_q;
   logic [CSR_DATA_W-1:0] nwords_q;
   logic                  tlast_seen_q;
   logic                  accept;
   logic                  lane_wr;
   logic                  last_lane;

   // Full blocks input outright, also for beats that would not commit
   assign axis_tready_o = enable_i & (state_q == ST_ACCEPT) & ~fifo_full_i &
                          ~(~mode_i & tlast_seen_q);

   assign accept    = axis_tvalid_i & axis_tready_o;
   assign lane_wr   = accept | (state_q == ST_PAD);
   assign last_lane = (lane_q == LAST_LANE);

   always_comb begin
      lane_we_o         = '0;
      lane_we_o[lane_q] = lane_wr;
   end

   // Zeros fill the upper lanes after a short packet
   assign lane_wdata_o  = (state_q == ST_PAD) ? '0 : axis_tdata_i;
   assign wr_addr_o     = wr_ptr_q;
   assign word_commit_o = lane_wr & last_lane;
   assign nwords_o      = nwords_q;
   assign tlast_seen_o  = tlast_seen_q;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i || sw_rst_i) begin
         state_q  <= ST_ACCEPT;
         lane_q   <= '0;
         wr_ptr_q <= '0;
      end else begin
         if (lane_wr) begin
            lane_q <= last_lane ? '0 : lane_q + 1'b1;
         end
         if (word_commit_o) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         case (state_q)
            ST_ACCEPT: begin
               if (accept && axis_tlast_i && !last_lane) begin
                  state_q <= ST_PAD;
               end
            end
            default: begin
               if (last_lane) begin
                  state_q <= ST_ACCEPT;
               end
            end
         endcase
      end
   end

   // Beat count freezes once the tlast beat itself is counted
   always_ff @(posedge clk_i) begin
      if (!rst_n_i || sw_rst_i) begin
         nwords_q     <= '0;
         tlast_seen_q <= 1'b0;
      end else begin
         if (accept && !tlast_seen_q) begin
            nwords_q <= nwords_q + 1'b1;
         end
         if (accept && axis_tlast_i) begin
            tlast_seen_q <= 1'b1;
         end
      end
   end

endmodule

//--- logic/axis_in_lane_ram.sv
//==========================================================================
// One lane bank of the word FIFO, simple dual port with registered read
//==========================================================================

module axis_in_lane_ram
   import axis_in_pkg::*;
#(
   parameter int TDATA_W = TDATA_W_DEF,
   parameter int ADDR_W  = ADDR_W_DEF
) (
   input  logic               clk_i,
   input  logic               we_i,
   input  logic [ ADDR_W-1:0] waddr_i,
   input  logic [TDATA_W-1:0] wdata_i,
   input  logic               re_i,
   input  logic [ ADDR_W-1:0] raddr_i,
   output logic [TDATA_W-1:0] rdata_o
);

   logic [TDATA_W-1:0] mem_q[2**ADDR_W];

   always_ff @(posedge clk_i) begin
      if (we_i) begin
         mem_q[waddr_i] <= wdata_i;
      end
   end

   // Output stays put until the next read, the reader relies on this
   always_ff @(posedge clk_i) begin
      if (re_i) begin
         rdata_o <= mem_q[raddr_i];
      end
   end

endmodule

//--- logic/axis_in_pkg.sv
//==========================================================================
// Shared constants of the AXI-Stream input peripheral: default widths,
// register map and the bit positions inside CTRL and STATUS
//==========================================================================

package axis_in_pkg;

   // Default datapath sizes
   localparam int TDATA_W_DEF = 8;
   localparam int LANES_DEF   = 4;
   localparam int ADDR_W_DEF  = 4;

   // Register port widths
   localparam int CSR_ADDR_W = 3;
   localparam int CSR_DATA_W = 32;

   // Register map
   localparam logic [CSR_ADDR_W-1:0] CSR_CTRL   = 3'd0;
   localparam logic [CSR_ADDR_W-1:0] CSR_THRESH = 3'd1;
   localparam logic [CSR_ADDR_W-1:0] CSR_STATUS = 3'd2;
   localparam logic [CSR_ADDR_W-1:0] CSR_LEVEL  = 3'd3;
   localparam logic [CSR_ADDR_W-1:0] CSR_NWORDS = 3'd4;
   localparam logic [CSR_ADDR_W-1:0] CSR_DATA   = 3'd5;

   // CTRL bits; MODE set selects the system stream output
   localparam int CTRL_ENABLE   = 0;
   localparam int CTRL_MODE     = 1;
   localparam int CTRL_SOFT_RST = 2;

   // STATUS bits
   localparam int ST_EMPTY = 0;
   localparam int ST_FULL  = 1;
   localparam int ST_TLAST = 2;

endpackage
